// File: dcache_arrays.sv
// Cache line storage
`timescale 1ns/10ps
`default_nettype none

module dcache_arrays (
	input  logic                   clk_i,
	input  logic                   crst_i,
	input  logic                   rd_en_i,
	input  dcache_pkg::set_idx_t   rd_set_i,
	output dcache_pkg::tag_t       rd_tag_o,
	output dcache_pkg::word_t      rd_data_o,
	output dcache_pkg::byte_mask_t rd_mask_o,
	output logic                   rd_valid_o,
	input  logic                   wr_en_i,
	input  dcache_pkg::set_idx_t   wr_set_i,
	input  dcache_pkg::tag_t       wr_tag_i,
	input  dcache_pkg::word_t      wr_data_i,
	input  dcache_pkg::byte_mask_t wr_mask_i,
	output logic                   active_o
);
	import dcache_pkg::*;

	tag_t                 tag_mem  [SET_COUNT];
	word_t                data_mem [SET_COUNT];
	byte_mask_t           mask_mem [SET_COUNT];
	logic [SET_COUNT-1:0] valid_q;

	// The cache is unusable from power-up until a first sweep has run.
	logic                 active_q    = 1'b0;
	logic                 sweep_q     = 1'b0;
	set_idx_t             sweep_idx_q = '0;

	always_ff @(posedge clk_i) begin
		if (wr_en_i) begin
			tag_mem[wr_set_i]  <= wr_tag_i;
			data_mem[wr_set_i] <= wr_data_i;
			mask_mem[wr_set_i] <= wr_mask_i;
		end
	end

	// Read outputs hold their value until the next enabled read.
	always_ff @(posedge clk_i) begin
		if (rd_en_i) begin
			rd_tag_o   <= tag_mem[rd_set_i];
			rd_data_o  <= data_mem[rd_set_i];
			rd_mask_o  <= mask_mem[rd_set_i];
			rd_valid_o <= valid_q[rd_set_i];
		end
	end

	// The sweep owns the valid bits while the cache is inactive.
	always_ff @(posedge clk_i) begin
		if (sweep_q) begin
			valid_q[sweep_idx_q] <= 1'b0;
		end else if (wr_en_i && active_q) begin
			valid_q[wr_set_i] <= 1'b1;
		end
	end

	// One set is cleared per cycle, counting down to set zero.
	always_ff @(posedge clk_i) begin
		if (crst_i) begin
			active_q    <= 1'b0;
			sweep_q     <= 1'b1;
			sweep_idx_q <= set_idx_t'(SET_COUNT - 1);
		end else if (sweep_q) begin
			if (sweep_idx_q == '0) begin
				sweep_q  <= 1'b0;
				active_q <= 1'b1;
			end
			sweep_idx_q <= sweep_idx_q - 1'b1;
		end
	end

	assign active_o = active_q;

endmodule

`default_nettype wire

// File: dcache_lookup.sv
// Cache request and lookup stage
`timescale 1ns/10ps
`default_nettype none

module dcache_lookup (
	input  logic                   clk_i,
	input  logic                   rst_i,
	input  logic                   crst_i,
	input  dcache_pkg::mem_req_t   m_req_i,
	output dcache_pkg::word_t      m_data_o,
	output logic                   m_rdy_o,
	output logic                   wbuf_push_o,
	output dcache_pkg::wr_entry_t  wbuf_entry_o,
	input  logic                   wbuf_full_i,
	output logic                   rd_rqst_o,
	output dcache_pkg::word_addr_t rd_addr_o,
	output dcache_pkg::byte_sel_t  rd_sel_o,
	input  logic                   rd_done_i,
	input  dcache_pkg::word_t      rd_data_i
);
	import dcache_pkg::*;

	// Request held for the compare cycle.
	pi_op_e     op_q;
	word_addr_t addr_q;
	word_t      data_q;
	byte_sel_t  sel_q;
	logic       cache_rdy_q;

	// Array write that committed on the same edge as the array read.
	logic       fwd_v_q;
	set_idx_t   fwd_set_q;
	tag_t       fwd_tag_q;
	word_t      fwd_data_q;
	byte_mask_t fwd_mask_q;

	word_t      refill_q;

	logic       accept;
	logic       arr_active;
	tag_t       arr_tag;
	word_t      arr_data;
	byte_mask_t arr_mask;
	logic       arr_valid;
	logic       arr_wr_en;

	logic       use_fwd;
	logic       line_valid;
	tag_t       line_tag;
	word_t      line_data;
	byte_mask_t line_mask;
	byte_mask_t sel_mask;
	logic       tag_hit;
	logic       hit;
	logic       rd_wait;
	word_t      new_data;
	word_t      merged_data;
	byte_mask_t merged_mask;

	dcache_arrays u_arrays (
		.clk_i      (clk_i),
		.crst_i     (crst_i),
		.rd_en_i    (accept),
		.rd_set_i   (addr_set(m_req_i.addr)),
		.rd_tag_o   (arr_tag),
		.rd_data_o  (arr_data),
		.rd_mask_o  (arr_mask),
		.rd_valid_o (arr_valid),
		.wr_en_i    (arr_wr_en),
		.wr_set_i   (addr_set(addr_q)),
		.wr_tag_i   (addr_tag(addr_q)),
		.wr_data_i  (merged_data),
		.wr_mask_i  (merged_mask),
		.active_o   (arr_active)
	);

	always_comb begin
		// The forwarded line replaces the array output when it hit the same set,
		// which covers a write followed at once by a read of the same address.
		use_fwd    = fwd_v_q && (fwd_set_q == addr_set(addr_q));
		line_valid = use_fwd || arr_valid;
		line_tag   = use_fwd ? fwd_tag_q : arr_tag;
		line_data  = use_fwd ? fwd_data_q : arr_data;
		line_mask  = use_fwd ? fwd_mask_q : arr_mask;

		sel_mask = sel_to_mask(sel_q);
		tag_hit  = line_valid && (line_tag == addr_tag(addr_q));
		hit      = cache_rdy_q && tag_hit && ((line_mask & sel_mask) == sel_mask);
		rd_wait  = (op_q == PI_RD) && !hit;

		// Writes and refills update only the selected bytes.
		arr_wr_en   = cache_rdy_q && ((op_q == PI_WR) || ((op_q == PI_RD) && rd_done_i));
		new_data    = (op_q == PI_WR) ? data_q : rd_data_i;
		merged_data = (new_data & sel_mask) | (line_data & ~sel_mask);
		merged_mask = (tag_hit ? line_mask : '0) | sel_mask;
	end

	assign accept   = m_rdy_o && (m_req_i.op != PI_NOOP);
	assign m_rdy_o  = !wbuf_full_i && !rd_wait;
	assign m_data_o = (op_q == PI_RD) ? line_data : refill_q;

	assign wbuf_push_o       = accept && (m_req_i.op == PI_WR);
	assign wbuf_entry_o.addr = m_req_i.addr;
	assign wbuf_entry_o.data = m_req_i.data;
	assign wbuf_entry_o.sel  = m_req_i.sel;

	assign rd_rqst_o = rd_wait;
	assign rd_addr_o = addr_q;
	assign rd_sel_o  = sel_q;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			op_q        <= PI_NOOP;
			cache_rdy_q <= 1'b0;
			fwd_v_q     <= 1'b0;
		end else if (m_rdy_o) begin
			op_q        <= m_req_i.op;
			cache_rdy_q <= arr_active && !crst_i;
			fwd_v_q     <= arr_wr_en;
		end else if ((op_q == PI_WR) || rd_done_i) begin
			// A write updates the arrays once, and a refill ends the read.
			op_q <= PI_NOOP;
		end
	end

	always_ff @(posedge clk_i) begin
		if (m_rdy_o) begin
			addr_q     <= m_req_i.addr;
			data_q     <= m_req_i.data;
			sel_q      <= m_req_i.sel;
			fwd_set_q  <= addr_set(addr_q);
			fwd_tag_q  <= addr_tag(addr_q);
			fwd_data_q <= merged_data;
			fwd_mask_q <= merged_mask;
		end
		if (rd_done_i) begin
			refill_q <= rd_data_i;
		end
	end

	// A pending refill keeps the master stalled until its data returns.
	assert property (@(posedge clk_i) disable iff (rst_i)
		rd_rqst_o && !rd_done_i |=> rd_rqst_o && !m_rdy_o);

	// The memory sequencer only completes a read that this stage asked for.
	assert property (@(posedge clk_i) disable iff (rst_i)
		rd_done_i |-> rd_rqst_o);

endmodule

`default_nettype wire

// File: dcache_mem_port.sv
// Memory port sequencer
`timescale 1ns/10ps
`default_nettype none

module dcache_mem_port (
	input  logic                   clk_i,
	input  logic                   rst_i,
	input  dcache_pkg::wr_entry_t  wbuf_head_i,
	input  logic                   wbuf_empty_i,
	output logic                   wbuf_pop_o,
	input  logic                   rd_rqst_i,
	input  dcache_pkg::word_addr_t rd_addr_i,
	input  dcache_pkg::byte_sel_t  rd_sel_i,
	output logic                   rd_done_o,
	output dcache_pkg::word_t      rd_data_o,
	output dcache_pkg::mem_req_t   s_req_o,
	input  dcache_pkg::word_t      s_data_i,
	input  logic                   s_rdy_i
);
	import dcache_pkg::*;

	port_state_e state_q;
	port_state_e state_d;
	logic        issue_wr;
	logic        issue_rd;

	always_comb begin
		// Buffered writes go first so memory sees them before a refill read.
		// Any cycle with s_rdy_i high also completes the outstanding op.
		issue_wr = s_rdy_i && !wbuf_empty_i;
		issue_rd = s_rdy_i && wbuf_empty_i && rd_rqst_i && (state_q != PORT_READING);

		if (issue_wr) begin
			state_d = PORT_WRITING;
		end else if (issue_rd) begin
			state_d = PORT_READING;
		end else if (s_rdy_i) begin
			state_d = PORT_IDLE;
		end else begin
			state_d = state_q;
		end
	end

	always_comb begin
		s_req_o.op   = PI_NOOP;
		s_req_o.addr = wbuf_head_i.addr;
		s_req_o.data = wbuf_head_i.data;
		s_req_o.sel  = wbuf_head_i.sel;
		if (issue_wr) begin
			s_req_o.op = PI_WR;
		end else if (issue_rd) begin
			s_req_o.op   = PI_RD;
			s_req_o.addr = rd_addr_i;
			s_req_o.sel  = rd_sel_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q <= PORT_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	assign wbuf_pop_o = issue_wr;
	assign rd_done_o  = (state_q == PORT_READING) && s_rdy_i;
	assign rd_data_o  = s_data_i;

	assert property (@(posedge clk_i) disable iff (rst_i)
		!s_rdy_i |-> (s_req_o.op == PI_NOOP) && !rd_done_o);

	// The master is stalled during a refill, so no write can slip in behind it.
	assert property (@(posedge clk_i) disable iff (rst_i)
		(state_q == PORT_READING) |-> wbuf_empty_i);

endmodule

`default_nettype wire

// File: dcache_pkg.sv
// Data cache definitions
`default_nettype none

package dcache_pkg;

	localparam int ARCH_BITS     = 32;
	localparam int SEL_BITS      = ARCH_BITS / 8;
	localparam int ADDR_BITS     = 30;
	localparam int SET_COUNT     = 16;
	localparam int SET_BITS      = 4;
	localparam int TAG_BITS      = ADDR_BITS - SET_BITS;
	localparam int WBUF_DEPTH    = 4;
	localparam int WBUF_PTR_BITS = $clog2(WBUF_DEPTH);

	typedef logic [ARCH_BITS-1:0] word_t;
	typedef logic [ADDR_BITS-1:0] word_addr_t;
	typedef logic [SEL_BITS-1:0]  byte_sel_t;
	typedef logic [ARCH_BITS-1:0] byte_mask_t;
	typedef logic [SET_BITS-1:0]  set_idx_t;
	typedef logic [TAG_BITS-1:0]  tag_t;

	// Code 3 is the read-write op of the bus and is not supported.
	typedef enum logic [1:0] {
		PI_NOOP = 2'd0,
		PI_WR   = 2'd1,
		PI_RD   = 2'd2
	} pi_op_e;

	typedef enum logic [1:0] {
		PORT_IDLE,
		PORT_READING,
		PORT_WRITING
	} port_state_e;

	typedef struct packed {
		pi_op_e     op;
		word_addr_t addr;
		word_t      data;
		byte_sel_t  sel;
	} mem_req_t;

	typedef struct packed {
		word_addr_t addr;
		word_t      data;
		byte_sel_t  sel;
	} wr_entry_t;

	// Each select bit covers one byte lane of the word.
	function automatic byte_mask_t sel_to_mask(input byte_sel_t sel);
		byte_mask_t mask;
		for (int i = 0; i < SEL_BITS; i++) begin
			mask[i*8 +: 8] = {8{sel[i]}};
		end
		return mask;
	endfunction

	function automatic tag_t addr_tag(input word_addr_t addr);
		return addr[ADDR_BITS-1:SET_BITS];
	endfunction

	function automatic set_idx_t addr_set(input word_addr_t addr);
		return addr[SET_BITS-1:0];
	endfunction

endpackage

`default_nettype wire

// File: dcache_top.sv
// Write-through data cache
`timescale 1ns/10ps
`default_nettype none

module dcache_top (
	input  logic                 clk_i,
	input  logic                 rst_i,
	input  logic                 crst_i,
	input  dcache_pkg::mem_req_t m_req_i,
	output dcache_pkg::word_t    m_data_o,
	output logic                 m_rdy_o,
	output dcache_pkg::mem_req_t s_req_o,
	input  dcache_pkg::word_t    s_data_i,
	input  logic                 s_rdy_i
);
	import dcache_pkg::*;

	// Lookup to write buffer.
	logic       wbuf_push;
	wr_entry_t  wbuf_entry;
	logic       wbuf_full;

	// Write buffer to memory sequencer.
	logic       wbuf_pop;
	wr_entry_t  wbuf_head;
	logic       wbuf_empty;

	// Refill handshake between lookup and the sequencer.
	logic       rd_rqst;
	word_addr_t rd_addr;
	byte_sel_t  rd_sel;
	logic       rd_done;
	word_t      rd_data;

	dcache_lookup u_lookup (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.crst_i       (crst_i),
		.m_req_i      (m_req_i),
		.m_data_o     (m_data_o),
		.m_rdy_o      (m_rdy_o),
		.wbuf_push_o  (wbuf_push),
		.wbuf_entry_o (wbuf_entry),
		.wbuf_full_i  (wbuf_full),
		.rd_rqst_o    (rd_rqst),
		.rd_addr_o    (rd_addr),
		.rd_sel_o     (rd_sel),
		.rd_done_i    (rd_done),
		.rd_data_i    (rd_data)
	);

	dcache_write_buffer u_write_buffer (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.push_i  (wbuf_push),
		.entry_i (wbuf_entry),
		.full_o  (wbuf_full),
		.pop_i   (wbuf_pop),
		.head_o  (wbuf_head),
		.empty_o (wbuf_empty)
	);

	dcache_mem_port u_mem_port (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.wbuf_head_i  (wbuf_head),
		.wbuf_empty_i (wbuf_empty),
		.wbuf_pop_o   (wbuf_pop),
		.rd_rqst_i    (rd_rqst),
		.rd_addr_i    (rd_addr),
		.rd_sel_i     (rd_sel),
		.rd_done_o    (rd_done),
		.rd_data_o    (rd_data),
		.s_req_o      (s_req_o),
		.s_data_i     (s_data_i),
		.s_rdy_i      (s_rdy_i)
	);

endmodule

`default_nettype wire

// File: dcache_write_buffer.sv
// Write-through buffer
`timescale 1ns/10ps
`default_nettype none

module dcache_write_buffer (
	input  logic                  clk_i,
	input  logic                  rst_i,
	input  logic                  push_i,
	input  dcache_pkg::wr_entry_t entry_i,
	output logic                  full_o,
	input  logic                  pop_i,
	output dcache_pkg::wr_entry_t head_o,
	output logic                  empty_o
);
	import dcache_pkg::*;

	wr_entry_t                mem_q [WBUF_DEPTH];
	logic [WBUF_PTR_BITS-1:0] wr_ptr_q;
	logic [WBUF_PTR_BITS-1:0] rd_ptr_q;
	logic [WBUF_PTR_BITS:0]   count_q;

	always_ff @(posedge clk_i) begin
		if (push_i) begin
			mem_q[wr_ptr_q] <= entry_i;
		end
	end

	// Pointers wrap naturally since the depth is a power of two.
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (push_i) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (pop_i) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			if (push_i && !pop_i) begin
				count_q <= count_q + 1'b1;
			end else if (pop_i && !push_i) begin
				count_q <= count_q - 1'b1;
			end
		end
	end

	assign head_o  = mem_q[rd_ptr_q];
	assign empty_o = (count_q == '0);

	// Full is flagged one entry early so the master sees it before the last slot.
	assign full_o = (count_q >= (WBUF_PTR_BITS + 1)'(WBUF_DEPTH - 1));

	assert property (@(posedge clk_i) disable iff (rst_i) !(push_i && full_o));

	assert property (@(posedge clk_i) disable iff (rst_i) !(pop_i && empty_o));

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Builds the data cache testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_dcache -f verilog.f -o sim_dcache; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_dcache > sim.log 2>&1
status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q '\*\*\* TEST PASSED \*\*\*' sim.log; then
	exit 0
fi

echo "Pass message not found in sim.log"
exit 1

// File: tb_dcache.sv
// Data cache testbench
`timescale 1ns/10ps
`default_nettype none

module tb_dcache;
	import dcache_pkg::*;

	localparam int N_RANDOM  = 400;
	localparam int N_BURST   = 40;
	localparam int WATCHDOG  = (N_RANDOM + N_BURST + 40) * 40 + 1000;
	localparam int EXP_ANY   = 0;
	localparam int EXP_HIT   = 1;
	localparam int EXP_MISS  = 2;
	localparam word_addr_t ADDR_A = {26'h0000a0c, 4'd8};
	localparam word_addr_t ADDR_B = {26'h0000b1d, 4'd9};

	logic       clk_i;
	logic       rst_i;
	logic       crst_i;
	mem_req_t   m_req;
	word_t      m_data;
	logic       m_rdy;
	mem_req_t   s_req;
	word_t      s_data;
	logic       s_rdy;
	logic [1:0] stall_level;
	int         rd_count;
	int         wr_count;
	mem_req_t   wr_last;
	int         model_errs;
	word_addr_t peek_addr;
	word_t      peek_data;

	word_t      shadow [word_addr_t];
	wr_entry_t  exp_wr [$];
	int         wr_seen = 0;
	int         errors = 0;
	int         checks = 0;
	logic       started = 1'b0;
	logic       saw_full = 1'b0;

	// The one read that may be waiting for its result.
	logic       rd_pend = 1'b0;
	word_addr_t pend_addr;
	word_t      pend_exp;
	word_t      pend_mask;
	int         pend_kind;
	int         pend_rd_count;

	dcache_top i_dut (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.crst_i   (crst_i),
		.m_req_i  (m_req),
		.m_data_o (m_data),
		.m_rdy_o  (m_rdy),
		.s_req_o  (s_req),
		.s_data_i (s_data),
		.s_rdy_i  (s_rdy)
	);

	tb_mem_model i_mem (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.stall_level_i (stall_level),
		.s_req_i       (s_req),
		.s_data_o      (s_data),
		.s_rdy_o       (s_rdy),
		.rd_count_o    (rd_count),
		.wr_count_o    (wr_count),
		.wr_last_o     (wr_last),
		.err_count_o   (model_errs),
		.peek_addr_i   (peek_addr),
		.peek_data_o   (peek_data)
	);

	function automatic word_t fill_word(input word_addr_t a);
		return {a, 2'b10} ^ 32'h9e37_79b9;
	endfunction

	function automatic word_t shadow_word(input word_addr_t a);
		return shadow.exists(a) ? shadow[a] : fill_word(a);
	endfunction

	function automatic word_t lane_mask(input byte_sel_t sel);
		word_t m;
		for (int i = 0; i < SEL_BITS; i++) begin
			m[i*8 +: 8] = sel[i] ? 8'hff : 8'h00;
		end
		return m;
	endfunction

	function automatic word_addr_t rand_addr();
		tag_t     t;
		set_idx_t s;
		t = ($urandom % 2 == 0) ? 26'h2a55a01 : 26'h1c3e7a0;
		case ($urandom % 3)
			0:       s = 4'd3;
			1:       s = 4'd7;
			default: s = 4'd11;
		endcase
		return {t, s};
	endfunction

	initial begin
		clk_i = 1'b0;
		forever #2 clk_i = ~clk_i;
	end

	// Called at a falling edge, when the outputs of the last rising edge are stable.
	task automatic check_result();
		if (rd_pend && m_rdy) begin
			checks++;
			assert ((m_data & pend_mask) == (pend_exp & pend_mask)) else begin
				errors++;
				$display("Fail at %0t: m_data_o = %h, expected %h (mask %h, addr %h)",
					$time, m_data & pend_mask, pend_exp & pend_mask, pend_mask, pend_addr);
			end
			if (pend_kind == EXP_HIT) begin
				assert (rd_count == pend_rd_count) else begin
					errors++;
					$display("Read of %h at %0t should hit but caused a memory read",
						pend_addr, $time);
				end
			end else if (pend_kind == EXP_MISS) begin
				assert (rd_count > pend_rd_count) else begin
					errors++;
					$display("Read of %h at %0t should miss but no memory read was issued",
						pend_addr, $time);
				end
			end
			rd_pend = 1'b0;
		end
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			#1;
			if (!started && !rst_i) begin
				assert (m_rdy && s_req.op == PI_NOOP) else begin
					errors++;
					$display("Cache not idle and ready at %0t before the first request", $time);
				end
			end
			@(negedge clk_i);
			check_result();
		end
	endtask

	task automatic send(input pi_op_e op, input word_addr_t addr, input word_t data,
		input byte_sel_t sel, input int kind);
		logic      done;
		wr_entry_t e;
		done    = 1'b0;
		started = 1'b1;
		m_req   = '{op: op, addr: addr, data: data, sel: sel};
		while (!done) begin
			#1;
			if (!m_rdy && !rd_pend) begin
				saw_full = 1'b1;
			end
			if (m_rdy) begin
				done = 1'b1;
				if (op == PI_WR) begin
					shadow[addr] = (shadow_word(addr) & ~lane_mask(sel)) | (data & lane_mask(sel));
					e = '{addr: addr, data: data, sel: sel};
					exp_wr.push_back(e);
				end else begin
					rd_pend       = 1'b1;
					pend_addr     = addr;
					pend_exp      = shadow_word(addr);
					pend_mask     = lane_mask(sel);
					pend_kind     = kind;
					pend_rd_count = rd_count;
				end
			end
			@(negedge clk_i);
			check_result();
		end
		m_req.op = PI_NOOP;
	endtask

	task automatic pulse_crst();
		crst_i = 1'b1;
		@(negedge clk_i);
		check_result();
		crst_i = 1'b0;
	endtask

	task automatic random_op();
		int        r;
		byte_sel_t sel;
		r   = $urandom % 16;
		sel = byte_sel_t'(1 + $urandom % 15);
		if (r == 0) begin
			idle(1);
		end else if (r < 8) begin
			send(PI_WR, rand_addr(), word_t'($urandom), sel, EXP_ANY);
		end else begin
			send(PI_RD, rand_addr(), '0, sel, EXP_ANY);
		end
	endtask

	// Every write seen by the memory must be the next accepted write.
	always @(posedge clk_i) begin
		if (!rst_i && wr_count != wr_seen) begin
			if (wr_seen >= exp_wr.size()) begin
				errors++;
				$display("Memory received a write at %0t that the master never issued", $time);
			end else begin
				checks++;
				assert (wr_last.addr == exp_wr[wr_seen].addr && wr_last.sel == exp_wr[wr_seen].sel
					&& wr_last.data == exp_wr[wr_seen].data) else begin
					errors++;
					$display("Fail at %0t: s_req_o write = %h/%h/%h, expected %h/%h/%h", $time,
						wr_last.addr, wr_last.data, wr_last.sel, exp_wr[wr_seen].addr,
						exp_wr[wr_seen].data, exp_wr[wr_seen].sel);
				end
			end
			wr_seen++;
		end
	end

	initial begin
		repeat (WATCHDOG) @(posedge clk_i);
		$display("Timeout: the run did not finish within %0d cycles", WATCHDOG);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		void'($urandom(32'hbede_9086));
		rst_i       = 1'b1;
		crst_i      = 1'b0;
		m_req       = '0;
		stall_level = 2'd0;
		peek_addr   = '0;
		repeat (5) @(negedge clk_i);
		rst_i = 1'b0;
		idle(2);
		pulse_crst();
		idle(20);

		// Full-word write, forwarded hit, then byte-valid hits and misses.
		send(PI_WR, ADDR_A, 32'h1234_5678, 4'hf, EXP_ANY);
		send(PI_RD, ADDR_A, '0, 4'hf, EXP_HIT);
		send(PI_RD, ADDR_A, '0, 4'h3, EXP_HIT);
		send(PI_RD, ADDR_B, '0, 4'h6, EXP_MISS);
		send(PI_RD, ADDR_B, '0, 4'h6, EXP_HIT);
		send(PI_RD, ADDR_B, '0, 4'h1, EXP_MISS);
		send(PI_RD, ADDR_B, '0, 4'h7, EXP_HIT);
		send(PI_WR, ADDR_B, 32'hcafe_0042, 4'h8, EXP_ANY);
		send(PI_RD, ADDR_B, '0, 4'hf, EXP_HIT);

		stall_level = 2'd1;
		for (int i = 0; i < N_RANDOM; i++) begin
			if (i == N_RANDOM / 2) begin
				pulse_crst();
			end
			random_op();
		end

		// Heavy stalls fill the write buffer.
		stall_level = 2'd3;
		for (int i = 0; i < N_BURST; i++) begin
			if (i % 8 == 7) begin
				send(PI_RD, rand_addr(), '0, 4'hf, EXP_ANY);
			end else begin
				send(PI_WR, rand_addr(), word_t'($urandom), byte_sel_t'(1 + $urandom % 15), EXP_ANY);
			end
		end
		stall_level = 2'd0;

		// Cache A and B again, then invalidate and expect misses.
		send(PI_RD, ADDR_A, '0, 4'hf, EXP_ANY);
		send(PI_RD, ADDR_A, '0, 4'hf, EXP_HIT);
		send(PI_RD, ADDR_B, '0, 4'hf, EXP_ANY);
		send(PI_RD, ADDR_B, '0, 4'hf, EXP_HIT);
		pulse_crst();
		idle(20);
		send(PI_RD, ADDR_A, '0, 4'hf, EXP_MISS);
		send(PI_RD, ADDR_B, '0, 4'hf, EXP_MISS);

		while (rd_pend || wr_seen != exp_wr.size()) begin
			idle(1);
		end
		foreach (shadow[a]) begin
			peek_addr = a;
			#1;
			checks++;
			assert (peek_data == shadow[a]) else begin
				errors++;
				$display("Fail at %0t: memory[%h] = %h, expected %h", $time, a, peek_data, shadow[a]);
			end
		end
		assert (saw_full) else begin
			errors++;
			$display("m_rdy_o never fell while the write buffer was full");
		end

		errors += model_errs;
		$display("Checks: %0d, errors: %0d, memory model errors: %0d", checks, errors, model_errs);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb_mem_model.sv
// Memory model with stalls
`timescale 1ns/10ps
`default_nettype none

module tb_mem_model (
	input  logic                   clk_i,
	input  logic                   rst_i,
	input  logic [1:0]             stall_level_i,
	input  dcache_pkg::mem_req_t   s_req_i,
	output dcache_pkg::word_t      s_data_o,
	output logic                   s_rdy_o,
	output int                     rd_count_o,
	output int                     wr_count_o,
	output dcache_pkg::mem_req_t   wr_last_o,
	output int                     err_count_o,
	input  dcache_pkg::word_addr_t peek_addr_i,
	output dcache_pkg::word_t      peek_data_o
);
	import dcache_pkg::*;

	word_t      mem [word_addr_t];
	logic       pending;
	word_addr_t pend_addr;
	logic       rdy;
	logic       in_rst;

	// Unwritten words hold a pattern built from the whole address.
	function automatic word_t fill_word(input word_addr_t a);
		return {a, 2'b10} ^ 32'h9e37_79b9;
	endfunction

	function automatic word_t read_word(input word_addr_t a);
		return mem.exists(a) ? mem[a] : fill_word(a);
	endfunction

	always_comb begin
		peek_data_o = read_word(peek_addr_i);
	end

	initial begin
		s_rdy_o     = 1'b0;
		s_data_o    = '0;
		rd_count_o  = 0;
		wr_count_o  = 0;
		wr_last_o   = '0;
		err_count_o = 0;
		pending     = 1'b0;
		pend_addr   = '0;
		in_rst      = 1'b1;
		forever begin
			// Reset takes effect at the rising edge, as in the DUT.
			@(posedge clk_i);
			in_rst = rst_i;
			@(negedge clk_i);
			if (in_rst) begin
				s_rdy_o = 1'b0;
				pending = 1'b0;
			end else begin
				rdy     = (stall_level_i == 2'd0) || (($urandom % 8) >= 2 * stall_level_i);
				s_rdy_o = rdy;
				s_data_o = (rdy && pending) ? read_word(pend_addr) : word_t'($urandom);
				// The request is sampled once the ready level has settled.
				#1;
				if (rdy && pending) begin
					pending = 1'b0;
				end
				if (s_req_i.op != PI_NOOP) begin
					if (!rdy) begin
						err_count_o++;
						$display("Memory op issued at %0t while the memory was not ready", $time);
					end else if (s_req_i.op == PI_WR) begin
						mem[s_req_i.addr] = read_word(s_req_i.addr);
						for (int i = 0; i < SEL_BITS; i++) begin
							if (s_req_i.sel[i]) begin
								mem[s_req_i.addr][i*8 +: 8] = s_req_i.data[i*8 +: 8];
							end
						end
						wr_last_o = s_req_i;
						wr_count_o++;
					end else if (s_req_i.op == PI_RD) begin
						pending   = 1'b1;
						pend_addr = s_req_i.addr;
						rd_count_o++;
					end else begin
						err_count_o++;
						$display("Illegal memory op code 3 issued at %0t", $time);
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog.f
dcache_pkg.sv
dcache_arrays.sv
dcache_lookup.sv
dcache_write_buffer.sv
dcache_mem_port.sv
dcache_top.sv
tb_mem_model.sv
tb_dcache.sv
